//--- mem_sub.f
src/axi_pkg.sv
src/mem_pkg.sv
src/rd_req_if.sv
src/wr_req_if.sv
src/i_cache.sv
src/d_uncached_port.sv
src/axi_arbiter.sv
src/mem_sub_top.sv
test/mem_sub_checker.sv
test/tb_mem_sub.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f mem_sub.f --top-module tb_mem_sub \
    -o tb_mem_sub --Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_mem_sub 2>&1 | tee sim.log
grep -q "^test passed$" sim.log \
    && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- src/axi_arbiter.sv
module axi_arbiter (
    input  logic           i_aclk,
    input  logic           i_rst_n,

    rd_req_if.arbiter      inst,
    rd_req_if.arbiter      data,
    wr_req_if.arbiter      wr,

    output logic [3:0]     o_arid,
    output mem_pkg::word_t o_araddr,
    output axi_pkg::len_t  o_arlen,
    output logic [2:0]     o_arsize,
    output logic [1:0]     o_arburst,
    output logic           o_arvalid,
    input  logic           i_arready,

    input  logic [3:0]     i_rid,
    input  mem_pkg::word_t i_rdata,
    input  logic [1:0]     i_rresp,
    input  logic           i_rlast,
    input  logic           i_rvalid,
    output logic           o_rready,

    output logic [3:0]     o_awid,
    output mem_pkg::word_t o_awaddr,
    output axi_pkg::len_t  o_awlen,
    output logic [2:0]     o_awsize,
    output logic [1:0]     o_awburst,
    output logic           o_awvalid,
    input  logic           i_awready,

    output logic [3:0]     o_wid,
    output mem_pkg::word_t o_wdata,
    output mem_pkg::strb_t o_wstrb,
    output logic           o_wlast,
    output logic           o_wvalid,
    input  logic           i_wready,

    input  logic [3:0]     i_bid,
    input  logic [1:0]     i_bresp,
    input  logic           i_bvalid,
    output logic           o_bready
);

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_t;

    rd_state_t rd_state;
    logic      grant_data;
    logic      sel_data;
    logic      owned;

    // choice is locked once an address is shown, data side first
    assign sel_data = (rd_state == RD_IDLE) ? data.arvalid : grant_data;
    assign owned    = (rd_state == RD_DATA);

    assign o_arid    = sel_data ? axi_pkg::id_data : axi_pkg::id_inst;
    assign o_araddr  = sel_data ? data.araddr : inst.araddr;
    assign o_arlen   = sel_data ? data.arlen : inst.arlen;
    assign o_arsize  = axi_pkg::size_word;
    assign o_arburst = axi_pkg::burst_incr;
    assign o_arvalid = !owned && (sel_data ? data.arvalid : inst.arvalid);

    assign data.arready = i_arready && !owned && sel_data;
    assign inst.arready = i_arready && !owned && !sel_data;

    // R beats go to the holder of the grant
    assign o_rready    = owned && (grant_data ? data.rready : inst.rready);
    assign data.rvalid = i_rvalid && owned && grant_data;
    assign inst.rvalid = i_rvalid && owned && !grant_data;
    assign data.rdata  = i_rdata;
    assign inst.rdata  = i_rdata;
    assign data.rlast  = i_rlast;
    assign inst.rlast  = i_rlast;

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            rd_state   <= RD_IDLE;
            grant_data <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (o_arvalid) begin
                        grant_data <= sel_data;
                        rd_state   <= i_arready ? RD_DATA : RD_ADDR;
                    end
                end
                RD_ADDR: if (i_arready) rd_state <= RD_DATA;
                RD_DATA: begin
                    if (i_rvalid && o_rready && i_rlast) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // single-beat writes from the data port only
    assign o_awid    = axi_pkg::id_data;
    assign o_awaddr  = wr.awaddr;
    assign o_awlen   = '0;
    assign o_awsize  = axi_pkg::size_word;
    assign o_awburst = axi_pkg::burst_incr;
    assign o_awvalid = wr.awvalid;
    assign wr.awready = i_awready;

    assign o_wid    = axi_pkg::id_data;
    assign o_wdata  = wr.wdata;
    assign o_wstrb  = wr.wstrb;
    assign o_wlast  = 1'b1;
    assign o_wvalid = wr.wvalid;
    assign wr.wready = i_wready;

    assign wr.bvalid = i_bvalid;
    assign o_bready  = wr.bready;

endmodule

//--- src/axi_pkg.sv
package axi_pkg;

    // fixed ids, one per requesting port
    localparam logic [3:0] id_inst = 4'd0;
    localparam logic [3:0] id_data = 4'd1;

    // incrementing bursts of full words only
    localparam logic [1:0] burst_incr = 2'b01;
    localparam logic [2:0] size_word = 3'b010;

    localparam logic [1:0] resp_okay = 2'b00;

    // beats minus one
    typedef logic [7:0] len_t;

endpackage

//--- src/d_uncached_port.sv
module d_uncached_port (
    input  logic           i_aclk,
    input  logic           i_rst_n,

    input  logic           i_req,
    input  logic           i_we,
    input  mem_pkg::strb_t i_wstrb,
    input  mem_pkg::word_t i_vaddr,
    input  mem_pkg::word_t i_wdata,
    output logic           o_valid,
    output mem_pkg::word_t o_rdata,

    rd_req_if.requester    rd,
    wr_req_if.requester    wr
);

    typedef enum logic [2:0] {D_IDLE, D_RD_ADDR, D_RD_DATA, D_WR, D_RESP} state_t;

    state_t         state;
    mem_pkg::word_t addr_q;
    mem_pkg::word_t wdata_q;
    mem_pkg::strb_t wstrb_q;
    logic           aw_done;
    logic           w_done;

    assign rd.araddr  = addr_q;
    assign rd.arlen   = '0;
    assign rd.arvalid = (state == D_RD_ADDR);
    assign rd.rready  = (state == D_RD_DATA);

    // AW and W may complete in either order
    assign wr.awaddr  = addr_q;
    assign wr.awvalid = (state == D_WR) && !aw_done;
    assign wr.wdata   = wdata_q;
    assign wr.wstrb   = wstrb_q;
    assign wr.wvalid  = (state == D_WR) && !w_done;
    assign wr.bready  = (state == D_RESP);

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            state   <= D_IDLE;
            o_valid <= 1'b0;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                D_IDLE: begin
                    aw_done <= 1'b0;
                    w_done  <= 1'b0;
                    if (i_req) begin
                        state <= i_we ? D_WR : D_RD_ADDR;
                    end
                end
                D_RD_ADDR: if (rd.arready) state <= D_RD_DATA;
                D_RD_DATA: begin
                    if (rd.rvalid && rd.rlast) begin
                        state   <= D_IDLE;
                        o_valid <= 1'b1;
                    end
                end
                D_WR: begin
                    if (wr.awvalid && wr.awready) aw_done <= 1'b1;
                    if (wr.wvalid && wr.wready) w_done <= 1'b1;
                    if ((aw_done || wr.awready) && (w_done || wr.wready)) begin
                        state <= D_RESP;
                    end
                end
                D_RESP: begin
                    if (wr.bvalid) begin
                        state   <= D_IDLE;
                        o_valid <= 1'b1;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_aclk) begin
        if (state == D_IDLE && i_req) begin
            addr_q  <= mem_pkg::to_paddr(i_vaddr);
            wdata_q <= i_wdata;
            wstrb_q <= i_wstrb;
        end
        if (rd.rvalid && rd.rready) begin
            o_rdata <= rd.rdata;
        end
    end

endmodule

//--- src/i_cache.sv
module i_cache #(
    parameter int LINE_WORDS = 4,
    parameter int SET_COUNT  = 16
) (
    input  logic           i_aclk,
    input  logic           i_rst_n,

    input  logic           i_req,
    input  mem_pkg::word_t i_vaddr,
    output logic           o_valid,
    output mem_pkg::word_t o_data,

    rd_req_if.requester    mem
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int IDX_W = $clog2(SET_COUNT);
    localparam int TAG_W = 32 - 2 - OFF_W - IDX_W;

    typedef enum logic [1:0] {C_IDLE, C_ADDR, C_BEAT} state_t;

    state_t         state;
    mem_pkg::word_t paddr;
    mem_pkg::word_t req_addr;
    logic           req_unc;
    logic           hit;
    logic           beat;
    logic [OFF_W-1:0] beat_cnt;

    logic [IDX_W-1:0] idx, req_idx;
    logic [TAG_W-1:0] tag, req_tag;
    logic [OFF_W-1:0] off, req_off;

    logic [SET_COUNT-1:0] valid_q;
    logic [TAG_W-1:0]     tag_q  [SET_COUNT];
    mem_pkg::word_t       data_q [SET_COUNT][LINE_WORDS];

    assign paddr = mem_pkg::to_paddr(i_vaddr);

    // lookup fields of the incoming address
    assign idx = paddr[2+OFF_W +: IDX_W];
    assign tag = paddr[31 -: TAG_W];
    assign off = paddr[2 +: OFF_W];

    // same fields of the request being served
    assign req_idx = req_addr[2+OFF_W +: IDX_W];
    assign req_tag = req_addr[31 -: TAG_W];
    assign req_off = req_addr[2 +: OFF_W];

    assign hit = valid_q[idx] && (tag_q[idx] == tag) && !mem_pkg::is_uncached(i_vaddr);
    assign beat = mem.rvalid && mem.rready;

    // line-aligned burst for a refill, one beat otherwise
    assign mem.araddr  = req_unc ? req_addr : {req_addr[31:2+OFF_W], {(2+OFF_W){1'b0}}};
    assign mem.arlen   = req_unc ? '0 : axi_pkg::len_t'(LINE_WORDS - 1);
    assign mem.arvalid = (state == C_ADDR);
    assign mem.rready  = (state == C_BEAT);

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            state    <= C_IDLE;
            o_valid  <= 1'b0;
            valid_q  <= '0;
            beat_cnt <= '0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (i_req && hit) begin
                        o_valid <= 1'b1;
                    end else if (i_req) begin
                        state <= C_ADDR;
                    end
                end
                C_ADDR: begin
                    if (mem.arready) begin
                        state    <= C_BEAT;
                        beat_cnt <= '0;
                    end
                end
                C_BEAT: begin
                    if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (mem.rlast) begin
                            state   <= C_IDLE;
                            o_valid <= 1'b1;
                            if (!req_unc) begin
                                valid_q[req_idx] <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // request capture, arrays and reply word
    always_ff @(posedge i_aclk) begin
        if (state == C_IDLE && i_req) begin
            req_addr <= paddr;
            req_unc  <= mem_pkg::is_uncached(i_vaddr);
            if (hit) begin
                o_data <= data_q[idx][off];
            end
        end
        if (beat) begin
            if (!req_unc) begin
                data_q[req_idx][beat_cnt] <= mem.rdata;
            end
            // the wanted word may come anywhere in the burst
            if (req_unc || beat_cnt == req_off) begin
                o_data <= mem.rdata;
            end
            if (mem.rlast && !req_unc) begin
                tag_q[req_idx] <= req_tag;
            end
        end
    end

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;

    // unmapped segments of the MIPS address map
    localparam word_t kseg0_base = 32'h8000_0000;
    localparam word_t kseg1_base = 32'hA000_0000;

    // clears the segment bits
    localparam word_t seg_mask = 32'h1FFF_FFFF;

    // fixed translation, same as a simple MMU without a TLB
    function automatic word_t to_paddr(input word_t vaddr);
        word_t seg;
        seg = vaddr & ~seg_mask;
        if (seg == kseg0_base || seg == kseg1_base) begin
            return vaddr & seg_mask;
        end
        return vaddr;
    endfunction

    // kseg1 bypasses the caches
    function automatic logic is_uncached(input word_t vaddr);
        return (vaddr & ~seg_mask) == kseg1_base;
    endfunction

endpackage

//--- src/mem_sub_top.sv
module mem_sub_top #(
    parameter int LINE_WORDS = 4,
    parameter int SET_COUNT  = 16
) (
    input  logic           i_aclk,
    input  logic           i_rst_n,

    input  logic           i_inst_req,
    input  mem_pkg::word_t i_inst_addr,
    output logic           o_inst_valid,
    output mem_pkg::word_t o_inst_data,

    input  logic           i_data_req,
    input  logic           i_data_we,
    input  mem_pkg::strb_t i_data_wstrb,
    input  mem_pkg::word_t i_data_addr,
    input  mem_pkg::word_t i_data_wdata,
    output logic           o_data_valid,
    output mem_pkg::word_t o_data_rdata,

    output logic [3:0]     o_arid,
    output mem_pkg::word_t o_araddr,
    output axi_pkg::len_t  o_arlen,
    output logic [2:0]     o_arsize,
    output logic [1:0]     o_arburst,
    output logic           o_arvalid,
    input  logic           i_arready,
    input  logic [3:0]     i_rid,
    input  mem_pkg::word_t i_rdata,
    input  logic [1:0]     i_rresp,
    input  logic           i_rlast,
    input  logic           i_rvalid,
    output logic           o_rready,

    output logic [3:0]     o_awid,
    output mem_pkg::word_t o_awaddr,
    output axi_pkg::len_t  o_awlen,
    output logic [2:0]     o_awsize,
    output logic [1:0]     o_awburst,
    output logic           o_awvalid,
    input  logic           i_awready,
    output logic [3:0]     o_wid,
    output mem_pkg::word_t o_wdata,
    output mem_pkg::strb_t o_wstrb,
    output logic           o_wlast,
    output logic           o_wvalid,
    input  logic           i_wready,
    input  logic [3:0]     i_bid,
    input  logic [1:0]     i_bresp,
    input  logic           i_bvalid,
    output logic           o_bready
);

    rd_req_if inst_rd ();
    rd_req_if data_rd ();
    wr_req_if data_wr ();

    i_cache #(
        .LINE_WORDS (LINE_WORDS),
        .SET_COUNT  (SET_COUNT)
    ) i_cache (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_req   (i_inst_req),
        .i_vaddr (i_inst_addr),
        .o_valid (o_inst_valid),
        .o_data  (o_inst_data),
        .mem     (inst_rd.requester)
    );

    d_uncached_port d_uncached_port (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_req   (i_data_req),
        .i_we    (i_data_we),
        .i_wstrb (i_data_wstrb),
        .i_vaddr (i_data_addr),
        .i_wdata (i_data_wdata),
        .o_valid (o_data_valid),
        .o_rdata (o_data_rdata),
        .rd      (data_rd.requester),
        .wr      (data_wr.requester)
    );

    axi_arbiter axi_arbiter (
        .i_aclk    (i_aclk),
        .i_rst_n   (i_rst_n),
        .inst      (inst_rd.arbiter),
        .data      (data_rd.arbiter),
        .wr        (data_wr.arbiter),
        .o_arid    (o_arid),
        .o_araddr  (o_araddr),
        .o_arlen   (o_arlen),
        .o_arsize  (o_arsize),
        .o_arburst (o_arburst),
        .o_arvalid (o_arvalid),
        .i_arready (i_arready),
        .i_rid     (i_rid),
        .i_rdata   (i_rdata),
        .i_rresp   (i_rresp),
        .i_rlast   (i_rlast),
        .i_rvalid  (i_rvalid),
        .o_rready  (o_rready),
        .o_awid    (o_awid),
        .o_awaddr  (o_awaddr),
        .o_awlen   (o_awlen),
        .o_awsize  (o_awsize),
        .o_awburst (o_awburst),
        .o_awvalid (o_awvalid),
        .i_awready (i_awready),
        .o_wid     (o_wid),
        .o_wdata   (o_wdata),
        .o_wstrb   (o_wstrb),
        .o_wlast   (o_wlast),
        .o_wvalid  (o_wvalid),
        .i_wready  (i_wready),
        .i_bid     (i_bid),
        .i_bresp   (i_bresp),
        .i_bvalid  (i_bvalid),
        .o_bready  (o_bready)
    );

endmodule

//--- src/rd_req_if.sv
interface rd_req_if;

    // address channel
    mem_pkg::word_t araddr;
    axi_pkg::len_t  arlen;
    logic           arvalid;
    logic           arready;

    // data channel
    mem_pkg::word_t rdata;
    logic           rlast;
    logic           rvalid;
    logic           rready;

    modport requester (
        output araddr,
        output arlen,
        output arvalid,
        output rready,
        input  arready,
        input  rdata,
        input  rlast,
        input  rvalid
    );

    modport arbiter (
        input  araddr,
        input  arlen,
        input  arvalid,
        input  rready,
        output arready,
        output rdata,
        output rlast,
        output rvalid
    );

endinterface

//--- src/wr_req_if.sv
interface wr_req_if;

    mem_pkg::word_t awaddr;
    logic           awvalid;
    logic           awready;

    mem_pkg::word_t wdata;
    mem_pkg::strb_t wstrb;
    logic           wvalid;
    logic           wready;

    logic           bvalid;
    logic           bready;

    modport requester (
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  awready, wready, bvalid
    );

    modport arbiter (
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output awready, wready, bvalid
    );

endinterface

//--- test/mem_sub_checker.sv
module mem_sub_checker (
    input logic        i_aclk,
    input logic        i_rst_n,
    input logic        i_arvalid,
    input logic        i_arready,
    input logic [31:0] i_araddr,
    input logic        i_awvalid,
    input logic        i_awready,
    input logic        i_wvalid,
    input logic        i_wready,
    input logic        i_rvalid,
    input logic        i_rready,
    input logic        i_rlast
);

    // a read is open from the AR handshake through rlast
    logic rd_open;

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            rd_open <= 1'b0;
        end else if (i_arvalid && i_arready) begin
            rd_open <= 1'b1;
        end else if (i_rvalid && i_rready && i_rlast) begin
            rd_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
        else $error("arvalid dropped or araddr changed before arready");

    aw_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_awvalid && !i_awready |=> i_awvalid)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_wvalid && !i_wready |=> i_wvalid)
        else $error("wvalid dropped before wready");

    rready_owned: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        i_rready |-> rd_open)
        else $error("rready high with no read in flight");

endmodule

bind mem_sub_top mem_sub_checker i_mem_sub_checker (
    .i_aclk    (i_aclk),
    .i_rst_n   (i_rst_n),
    .i_arvalid (o_arvalid),
    .i_arready (i_arready),
    .i_araddr  (o_araddr),
    .i_awvalid (o_awvalid),
    .i_awready (i_awready),
    .i_wvalid  (o_wvalid),
    .i_wready  (i_wready),
    .i_rvalid  (i_rvalid),
    .i_rready  (o_rready),
    .i_rlast   (i_rlast)
);

//--- test/tb_mem_sub.sv
module tb_mem_sub;

    localparam int TIMEOUT = 200;

    logic        i_aclk, i_rst_n;
    logic        i_inst_req, o_inst_valid;
    logic [31:0] i_inst_addr, o_inst_data;
    logic        i_data_req, i_data_we, o_data_valid;
    logic [3:0]  i_data_wstrb;
    logic [31:0] i_data_addr, i_data_wdata, o_data_rdata;
    logic [3:0]  o_arid, i_rid, o_awid, o_wid, i_bid, o_wstrb;
    logic [31:0] o_araddr, i_rdata, o_awaddr, o_wdata;
    logic [7:0]  o_arlen, o_awlen;
    logic [2:0]  o_arsize, o_awsize;
    logic [1:0]  o_arburst, o_awburst, i_rresp, i_bresp;
    logic        o_arvalid, i_arready, i_rlast, i_rvalid, o_rready;
    logic        o_awvalid, i_awready, o_wlast, o_wvalid, i_wready, i_bvalid, o_bready;

    typedef struct {
        logic        port;
        logic        we;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] exp_ars;
        logic [31:0] exp_araddr;
        logic [31:0] exp_arlen;
    } op_t;

    op_t         ops[$];
    logic [31:0] mem_words [logic [31:0]];
    logic [3:0]  ar_ids[$];
    int          ar_count [16];
    logic [31:0] last_ar_addr;
    logic [7:0]  last_ar_len;
    logic [3:0]  last_ar_id;
    logic [31:0] rng_state = 32'h649d;
    int          err_count = 0;
    int          check_count = 0;

    mem_sub_top #(.LINE_WORDS(4), .SET_COUNT(16)) i_mem_sub_top (.*);

    initial begin
        i_aclk = 1'b0;
        forever #10 i_aclk = ~i_aclk;
    end

    task automatic next_cycle();
        @(posedge i_aclk);
        #2;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // 0 to 2 wait cycles
    function automatic int rand_delay();
        rng_state = xorshift(rng_state);
        return int'(rng_state % 3);
    endfunction

    // unwritten words read as address ^ 5a5a_0000
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        return addr ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_case(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d error(s)", name, err_count - errs_before);
        end
    endtask

    // AR and R channels of the slave
    initial begin : read_slave
        logic [31:0] addr;
        int          len;
        int          guard;
        forever begin
            next_cycle();
            if (o_arvalid === 1'b1) begin
                repeat (rand_delay()) next_cycle();
                addr = o_araddr;
                len = {24'd0, o_arlen};
                last_ar_id = o_arid;
                // four-byte incrementing bursts only
                check_val("o_arsize", {29'd0, o_arsize}, 32'd2);
                check_val("o_arburst", {30'd0, o_arburst}, 32'd1);
                i_arready = 1'b1;
                next_cycle();
                i_arready = 1'b0;
                ar_count[last_ar_id]++;
                ar_ids.push_back(last_ar_id);
                last_ar_addr = addr;
                last_ar_len = len[7:0];
                for (int b = 0; b <= len; b++) begin
                    repeat (rand_delay()) next_cycle();
                    i_rvalid = 1'b1;
                    i_rid = last_ar_id;
                    i_rdata = read_word(addr + 4 * b);
                    i_rlast = (b == len);
                    guard = 0;
                    while (o_rready !== 1'b1 && guard < TIMEOUT) begin
                        next_cycle();
                        guard++;
                    end
                    if (guard == TIMEOUT) begin
                        $display("timeout: read beat %0d was never accepted", b);
                        err_count++;
                    end
                    next_cycle();
                    i_rvalid = 1'b0;
                    i_rlast = 1'b0;
                end
            end
        end
    end

    // AW, W and B channels merge strobed bytes into the array
    initial begin : write_slave
        logic [31:0] addr, data;
        logic [3:0]  strb;
        logic        got_aw, got_w;
        int          guard;
        forever begin
            next_cycle();
            if (o_awvalid === 1'b1 || o_wvalid === 1'b1) begin
                got_aw = 1'b0;
                got_w = 1'b0;
                guard = 0;
                while (!(got_aw && got_w) && guard < TIMEOUT) begin
                    i_awready = !got_aw && o_awvalid && (rand_delay() != 0);
                    i_wready = !got_w && o_wvalid && (rand_delay() != 0);
                    if (i_awready) begin
                        addr = o_awaddr;
                        check_val("o_awid", {28'd0, o_awid}, 32'd1);
                        check_val("o_awlen", {24'd0, o_awlen}, 32'd0);
                        check_val("o_awsize", {29'd0, o_awsize}, 32'd2);
                        check_val("o_awburst", {30'd0, o_awburst}, 32'd1);
                    end
                    if (i_wready) begin
                        data = o_wdata;
                        strb = o_wstrb;
                        check_val("o_wid", {28'd0, o_wid}, 32'd1);
                        check_val("o_wlast", {31'd0, o_wlast}, 32'd1);
                    end
                    next_cycle();
                    got_aw |= i_awready;
                    got_w |= i_wready;
                    i_awready = 1'b0;
                    i_wready = 1'b0;
                    guard++;
                end
                if (guard == TIMEOUT) begin
                    $display("timeout: write address or data never arrived");
                    err_count++;
                end
                mem_words[addr] = merge_bytes(read_word(addr), data, strb);
                repeat (rand_delay()) next_cycle();
                i_bvalid = 1'b1;
                guard = 0;
                while (o_bready !== 1'b1 && guard < TIMEOUT) begin
                    next_cycle();
                    guard++;
                end
                if (guard == TIMEOUT) begin
                    $display("timeout: write response was never accepted");
                    err_count++;
                end
                next_cycle();
                i_bvalid = 1'b0;
            end
        end
    end

    task automatic load_table();
        // instruction line at 0x40, hits, conflict at 0x1040, then back
        ops.push_back('{1'b0, 1'b0, 32'h8000_0040, 4'h0, 0, 32'h5a5a_0040, 1, 'h40, 3});
        ops.push_back('{1'b0, 1'b0, 32'h8000_0044, 4'h0, 0, 32'h5a5a_0044, 0, 0, 0});
        ops.push_back('{1'b0, 1'b0, 32'h8000_0048, 4'h0, 0, 32'h5a5a_0048, 0, 0, 0});
        ops.push_back('{1'b0, 1'b0, 32'h8000_004c, 4'h0, 0, 32'h5a5a_004c, 0, 0, 0});
        ops.push_back('{1'b0, 1'b0, 32'h8000_1044, 4'h0, 0, 32'h5a5a_1044, 1, 'h1040, 3});
        ops.push_back('{1'b0, 1'b0, 32'h8000_0048, 4'h0, 0, 32'h5a5a_0048, 1, 'h40, 3});
        // kseg1 fetches never hit
        ops.push_back('{1'b0, 1'b0, 32'ha000_2004, 4'h0, 0, 32'h5a5a_2004, 1, 'h2004, 0});
        ops.push_back('{1'b0, 1'b0, 32'ha000_2004, 4'h0, 0, 32'h5a5a_2004, 1, 'h2004, 0});
        // partial writes then read back
        ops.push_back('{1'b1, 1'b1, 32'ha000_0100, 4'b0011, 32'h1122_3344, 0, 0, 0, 0});
        ops.push_back('{1'b1, 1'b0, 32'ha000_0100, 4'h0, 0, 32'h5a5a_3344, 1, 'h100, 0});
        ops.push_back('{1'b1, 1'b1, 32'ha000_0100, 4'b1000, 32'haabb_ccdd, 0, 0, 0, 0});
        ops.push_back('{1'b1, 1'b0, 32'ha000_0100, 4'h0, 0, 32'haa5a_3344, 1, 'h100, 0});
        ops.push_back('{1'b1, 1'b1, 32'ha000_0104, 4'b0110, 32'h1234_5678, 0, 0, 0, 0});
        ops.push_back('{1'b1, 1'b0, 32'ha000_0104, 4'h0, 0, 32'h5a34_5604, 1, 'h104, 0});
    endtask

    // issues one request and waits for its reply strobe
    task automatic request(input op_t op, output int lat, output logic [31:0] rdata);
        logic done;
        done = 1'b0;
        lat = 0;
        rdata = '0;
        if (op.port) begin
            i_data_req = 1'b1;
            i_data_we = op.we;
            i_data_addr = op.addr;
            i_data_wstrb = op.strb;
            i_data_wdata = op.wdata;
        end else begin
            i_inst_req = 1'b1;
            i_inst_addr = op.addr;
        end
        while (!done && lat < TIMEOUT) begin
            next_cycle();
            lat++;
            i_inst_req = 1'b0;
            i_data_req = 1'b0;
            if (op.port ? o_data_valid : o_inst_valid) begin
                done = 1'b1;
                rdata = op.port ? o_data_rdata : o_inst_data;
            end
        end
        if (!done) begin
            $display("timeout: no reply to the request at %h", op.addr);
            err_count++;
        end
    endtask

    task automatic idle_after_reset();
        int errs;
        errs = err_count;
        for (int c = 0; c < 8; c++) begin
            next_cycle();
            check_val("valids {inst,data,ar,aw,w,rready,bready}",
                      {25'd0, o_inst_valid, o_data_valid, o_arvalid, o_awvalid,
                       o_wvalid, o_rready, o_bready}, 32'd0);
        end
        report_case("idle after reset", errs);
    endtask

    task automatic run_table();
        int          lat, base, errs;
        logic [31:0] got;
        foreach (ops[n]) begin
            errs = err_count;
            base = ar_count[ops[n].port];
            request(ops[n], lat, got);
            if (!ops[n].we) begin
                check_val(ops[n].port ? "o_data_rdata" : "o_inst_data", got, ops[n].exp_data);
            end
            check_val("ar count", ar_count[ops[n].port] - base, ops[n].exp_ars);
            if (ops[n].exp_ars != 0) begin
                check_val("araddr", last_ar_addr, ops[n].exp_araddr);
                check_val("arlen", {24'd0, last_ar_len}, ops[n].exp_arlen);
                check_val("arid", {28'd0, last_ar_id}, ops[n].port ? 32'd1 : 32'd0);
            end else if (!ops[n].port) begin
                check_val("hit latency", lat, 32'd1);
            end
            report_case($sformatf("case %0d addr %h", n, ops[n].addr), errs);
        end
    endtask

    // instruction miss and data read in the same cycle
    task automatic fetch_and_read_together();
        int          cycles, errs, first;
        logic        inst_done, data_done;
        logic [31:0] inst_got, data_got;
        errs = err_count;
        first = ar_ids.size();
        inst_done = 1'b0;
        data_done = 1'b0;
        cycles = 0;
        i_inst_req = 1'b1;
        i_inst_addr = 32'h8000_0080;
        i_data_req = 1'b1;
        i_data_we = 1'b0;
        i_data_addr = 32'ha000_0200;
        while (!(inst_done && data_done) && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
            i_inst_req = 1'b0;
            i_data_req = 1'b0;
            if (o_inst_valid) begin
                inst_done = 1'b1;
                inst_got = o_inst_data;
            end
            if (o_data_valid) begin
                data_done = 1'b1;
                data_got = o_data_rdata;
            end
        end
        if (!(inst_done && data_done)) begin
            $display("timeout: concurrent fetch and data read did not both reply");
            err_count++;
        end
        check_val("o_inst_data", inst_got, 32'h5a5a_0080);
        check_val("o_data_rdata", data_got, 32'h5a5a_0200);
        check_val("first arid", (ar_ids.size() > first) ? {28'd0, ar_ids[first]} : 32'hx,
                  32'd1);
        report_case("concurrent fetch and data read", errs);
    endtask

    initial begin : stimulus
        i_rst_n = 1'b0;
        i_inst_req = 1'b0;
        i_inst_addr = '0;
        i_data_req = 1'b0;
        i_data_we = 1'b0;
        i_data_wstrb = '0;
        i_data_addr = '0;
        i_data_wdata = '0;
        i_arready = 1'b0;
        i_rid = '0;
        i_rdata = '0;
        i_rresp = 2'b00;
        i_rlast = 1'b0;
        i_rvalid = 1'b0;
        i_awready = 1'b0;
        i_wready = 1'b0;
        i_bid = 4'd1;
        i_bresp = 2'b00;
        i_bvalid = 1'b0;
        load_table();
        repeat (3) @(posedge i_aclk);
        #2;
        i_rst_n = 1'b1;
        idle_after_reset();
        run_table();
        fetch_and_read_together();
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
